// ==== Makefile ====
# Verilator flow for the static-memory multiple access controller

VERILATOR ?= verilator
TOP       ?= smc_mac_tb
RTL_TOP   ?= smc_mac_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
verilog/smc_size_pkg.sv
verilog/smc_ctrl_pkg.sv
verilog/smc_cfg_regs.sv
verilog/smc_access_seq.sv
verilog/smc_data_path.sv
verilog/smc_mac_top.sv
verif/smc_ext_mem.sv
verif/smc_mac_tb.sv

// ==== verif/smc_ext_mem.sv ====
`timescale 1ns/1ps

module smc_ext_mem
  import smc_size_pkg::*;
  import smc_ctrl_pkg::*;
#(
  parameter int MAX_DELAY = 6                 // cycles before an access may complete
)
(
  input  logic              sys_clk6,
  input  logic              n_sys_reset6,
  input  logic              stall,            // holds back every completion
  input  logic              mem_valid,
  input  acc_op_e           mem_op,
  input  logic [DATA_W-1:0] mem_wdata,
  output logic              mem_credit,
  output logic              mem_rvalid,
  output logic [DATA_W-1:0] mem_rdata
);

  int unsigned       cyc;                     // local cycle count
  int unsigned       due_q [$];               // earliest completion cycle per access
  acc_op_e           op_q [$];
  logic [DATA_W-1:0] word_q [$];              // one word held per request

  // ------------------------------------------------------------------------
  // accept accesses, complete them strictly in order
  // ------------------------------------------------------------------------

  always @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
    begin
      cyc = 0;
      due_q.delete();
      op_q.delete();
      word_q.delete();
      mem_credit <= 1'b0;
      mem_rvalid <= 1'b0;
      mem_rdata  <= '0;
    end
    else
    begin
      cyc = cyc + 1;
      if (mem_valid)
      begin
        due_q.push_back(cyc + $urandom_range(MAX_DELAY, 0));
        op_q.push_back(mem_op);
        // reads get a fresh random word, writes keep what was sent
        word_q.push_back((mem_op == OP_WRITE) ? mem_wdata : $urandom);
      end
      mem_credit <= 1'b0;                     // pulses only
      mem_rvalid <= 1'b0;
      if (!stall && (due_q.size() != 0) && (due_q[0] <= cyc))
      begin
        mem_credit <= 1'b1;                   // one completion per cycle at most
        if (op_q[0] == OP_READ)
        begin
          mem_rvalid <= 1'b1;                 // same cycle as its credit
          mem_rdata  <= word_q[0];
        end
        void'(due_q.pop_front());
        void'(op_q.pop_front());
        void'(word_q.pop_front());
      end
    end
  end

endmodule

// ==== verif/smc_mac_tb.sv ====
`timescale 1ns/1ps

module smc_mac_tb
  import smc_size_pkg::*;
  import smc_ctrl_pkg::*;
();

  localparam int CREDIT_MAX = 3;              // fewer than the widest split
  localparam int MEM_DELAY  = 6;
  localparam int NUM_XFERS  = 23;
  localparam int WATCHDOG   = 200 * NUM_XFERS + 40;  // cycles, reset and tail included

  logic              sys_clk6;
  logic              n_sys_reset6;
  logic              req_valid;
  acc_op_e           req_op;
  xfer_size_e        req_size;
  logic [DATA_W-1:0] req_wdata;
  logic              req_ready;
  logic              done;
  logic [DATA_W-1:0] rd_data;
  logic              cfg_we;
  xfer_size_e        cfg_bus_size;
  logic              mem_valid;
  acc_op_e           mem_op;
  logic [DATA_W-1:0] mem_wdata;
  logic              mem_credit;
  logic              mem_rvalid;
  logic [DATA_W-1:0] mem_rdata;
  logic              stall;

  int                errors;
  int                checks;
  int                done_count;              // done pulses seen
  int                xfer_count;              // transfers finished by the driver
  int                tb_credits;              // credits the DUT should hold
  int                bi;
  int                si;
  xfer_size_e        bus_now;                 // width the next request will see
  xfer_size_e        size_list [3];
  logic [DATA_W-1:0] wr_log [$];
  acc_op_e           op_log [$];
  logic [DATA_W-1:0] rd_log [$];              // read words in return order

  smc_mac_top #(
    .CREDIT_MAX (CREDIT_MAX)
  ) u_dut (
    .sys_clk6     (sys_clk6),
    .n_sys_reset6 (n_sys_reset6),
    .req_valid    (req_valid),
    .req_op       (req_op),
    .req_size     (req_size),
    .req_wdata    (req_wdata),
    .req_ready    (req_ready),
    .done         (done),
    .rd_data      (rd_data),
    .cfg_we       (cfg_we),
    .cfg_bus_size (cfg_bus_size),
    .mem_valid    (mem_valid),
    .mem_op       (mem_op),
    .mem_wdata    (mem_wdata),
    .mem_credit   (mem_credit),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata    (mem_rdata)
  );

  smc_ext_mem #(
    .MAX_DELAY (MEM_DELAY)
  ) u_mem (
    .sys_clk6     (sys_clk6),
    .n_sys_reset6 (n_sys_reset6),
    .stall        (stall),
    .mem_valid    (mem_valid),
    .mem_op       (mem_op),
    .mem_wdata    (mem_wdata),
    .mem_credit   (mem_credit),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata    (mem_rdata)
  );

  initial
  begin
    sys_clk6 = 1'b0;
    forever #20 sys_clk6 = ~sys_clk6;         // 40 ns period
  end

  // ------------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------------

  function automatic int size_bytes(input xfer_size_e s);
    case (s)
      SIZE_8:  return 1;
      SIZE_16: return 2;
      default: return 4;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] byte_mask(input int nbytes);
    case (nbytes)
      1:       return 32'h0000_00ff;
      2:       return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  // access count, write part per index and read result of one transfer
  function automatic void ref_xfer(input xfer_size_e size, input xfer_size_e bus,
                                   input logic [DATA_W-1:0] wdata,
                                   input logic [DATA_W-1:0] ret_words [4],
                                   output int n_acc,
                                   output logic [DATA_W-1:0] wparts [4],
                                   output logic [DATA_W-1:0] rdata);
    int                xb;
    int                bb;
    int                k;
    logic [DATA_W-1:0] word;
    xb    = size_bytes(size);
    bb    = size_bytes(bus);
    n_acc = (xb > bb) ? (xb / bb) : 1;        // at least one access
    word  = '0;
    for (k = 0; k < 4; k++)
      wparts[k] = '0;
    for (k = 0; k < n_acc; k++)
    begin
      // part k sits on the low lanes, only as wide as the narrower side
      wparts[k] = (wdata >> (8 * bb * k)) & byte_mask((xb < bb) ? xb : bb);
      // first word back belongs to the highest index
      word = word | ((ret_words[n_acc - 1 - k] & byte_mask(bb)) << (8 * bb * k));
    end
    case (xb)
      1:       rdata = {4{word[7:0]}};
      2:       rdata = {2{word[15:0]}};
      default: rdata = word;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  // ------------------------------------------------------------------------
  // monitor, sampled at the falling edge where everything is settled
  // ------------------------------------------------------------------------

  always @(negedge sys_clk6)
  begin
    if (n_sys_reset6)
    begin
      if (mem_valid && (tb_credits == 0))
      begin
        errors++;
        $display("credit error: mem_valid issued with no credit left at %0t", $time);
      end
      if (mem_valid)
      begin
        wr_log.push_back(mem_wdata);
        op_log.push_back(mem_op);
      end
      if (mem_rvalid)
        rd_log.push_back(mem_rdata);
      if (done)
        done_count++;
      tb_credits = tb_credits + int'(mem_credit) - int'(mem_valid);  // applied next edge
    end
  end

  // ------------------------------------------------------------------------
  // driver tasks
  // ------------------------------------------------------------------------

  task automatic set_bus(input xfer_size_e b);
    @(negedge sys_clk6);
    while (!req_ready)
      @(negedge sys_clk6);
    cfg_we       = 1'b1;                      // idle write, lands next cycle
    cfg_bus_size = b;
    @(negedge sys_clk6);
    cfg_we  = 1'b0;
    bus_now = b;
  endtask

  // one transfer, optional credit stall and a config write while busy
  task automatic run_xfer(input acc_op_e op, input xfer_size_e size,
                          input logic [DATA_W-1:0] wdata, input int hold,
                          input xfer_size_e mid_cfg);
    int                n_exp;
    int                cyc;
    int                i;
    logic [DATA_W-1:0] parts [4];
    logic [DATA_W-1:0] words [4];
    logic [DATA_W-1:0] rd_exp;
    @(negedge sys_clk6);
    while (!req_ready)
      @(negedge sys_clk6);
    check_val("done_count", done_count, xfer_count);  // one pulse per transfer
    wr_log.delete();
    op_log.delete();
    rd_log.delete();
    stall     = (hold > 0);
    req_valid = 1'b1;
    req_op    = op;
    req_size  = size;
    req_wdata = wdata;                        // held until done
    @(negedge sys_clk6);
    req_valid = 1'b0;
    cyc = 0;
    while (!done)
    begin
      cfg_we = (cyc == 0) && (mid_cfg != SIZE_RSVD);  // lands while busy
      if (cfg_we)
        cfg_bus_size = mid_cfg;
      stall = (cyc < hold);
      @(negedge sys_clk6);
      cyc++;
    end
    cfg_we = 1'b0;
    stall  = 1'b0;
    for (i = 0; i < 4; i++)
    begin
      words[i] = '0;
      if (i < rd_log.size())
        words[i] = rd_log[i];
    end
    ref_xfer(size, bus_now, wdata, words, n_exp, parts, rd_exp);
    check_val("access_count", op_log.size(), n_exp);
    for (i = 0; (i < op_log.size()) && (i < n_exp); i++)
    begin
      check_val("mem_op", 32'(op_log[i]), 32'(op));
      if (op == OP_WRITE)
        check_val("mem_wdata", wr_log[i], parts[n_exp - 1 - i]);  // msb part first
    end
    if (op == OP_READ)
    begin
      check_val("read_returns", rd_log.size(), n_exp);
      check_val("rd_data", rd_data, rd_exp);
    end
    xfer_count++;
    if (mid_cfg != SIZE_RSVD)
      bus_now = mid_cfg;                      // parked width for the next one
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial
  begin
    void'($urandom(84581));
    errors       = 0;
    checks       = 0;
    done_count   = 0;
    xfer_count   = 0;
    tb_credits   = CREDIT_MAX;
    bus_now      = SIZE_32;                   // reset width
    size_list    = '{SIZE_8, SIZE_16, SIZE_32};
    n_sys_reset6 = 1'b0;
    req_valid    = 1'b0;
    req_op       = OP_READ;
    req_size     = SIZE_8;
    req_wdata    = '0;
    cfg_we       = 1'b0;
    cfg_bus_size = SIZE_32;
    stall        = 1'b0;
    repeat (5) @(negedge sys_clk6);
    n_sys_reset6 = 1'b1;
    @(negedge sys_clk6);
    check_val("req_ready", 32'(req_ready), 32'd1);
    check_val("mem_valid", 32'(mem_valid), 32'd0);
    check_val("done", 32'(done), 32'd0);

    // every size on every bus width, write then read
    for (bi = 0; bi < 3; bi++)
    begin
      set_bus(size_list[bi]);
      for (si = 0; si < 3; si++)
      begin
        run_xfer(OP_WRITE, size_list[si], $urandom, 0, SIZE_RSVD);
        run_xfer(OP_READ, size_list[si], '0, 0, SIZE_RSVD);
      end
    end

    // credits withheld for a while on the narrow bus
    set_bus(SIZE_8);
    run_xfer(OP_READ, SIZE_32, '0, 40, SIZE_RSVD);
    run_xfer(OP_WRITE, SIZE_32, $urandom, 40, SIZE_RSVD);

    // width change during a transfer only hits the next one
    set_bus(SIZE_32);
    run_xfer(OP_WRITE, SIZE_32, $urandom, 0, SIZE_8);
    run_xfer(OP_READ, SIZE_32, '0, 0, SIZE_16);
    run_xfer(OP_WRITE, SIZE_32, $urandom, 0, SIZE_RSVD);

    repeat (2 * MEM_DELAY + 8) @(negedge sys_clk6);  // trailing write credits
    check_val("done_count", done_count, xfer_count);
    check_val("credits", 32'(u_dut.u_access_seq.credits), CREDIT_MAX);  // pool refilled
    $display("summary: %0d transfers, %0d checks, %0d errors", xfer_count, checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // hang guard
  initial
  begin
    repeat (WATCHDOG) @(posedge sys_clk6);
    errors++;
    $display("timeout: run did not finish within %0d cycles, %0d errors", WATCHDOG, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== verilog/smc_access_seq.sv ====
`timescale 1ns/1ps

module smc_access_seq
  import smc_size_pkg::*;
  import smc_ctrl_pkg::*;
#(
  parameter int CREDIT_MAX = 4                // 1..7
)
(
  input  logic       sys_clk6,
  input  logic       n_sys_reset6,
  input  logic       req_valid,
  input  acc_op_e    req_op,
  input  xfer_size_e req_size,
  input  xfer_size_e bus_size,
  output logic       req_ready,
  output logic       busy,
  output xfer_size_e cur_size,
  output xfer_size_e cur_bus,
  output acc_op_e    cur_op,
  output acc_cnt_t   issue_idx,
  output logic       issue_fire,
  output acc_cnt_t   ret_idx,
  output logic       ret_fire,
  output logic       done,
  output logic       mem_valid,
  output acc_op_e    mem_op,
  input  logic       mem_credit,
  input  logic       mem_rvalid
);

  seq_state_e state;
  credit_t    credits;                        // accesses the memory can still take

  assign req_ready  = (state == S_IDLE);
  assign busy       = (state == S_ISSUE) || (state == S_DRAIN);  // S_DONE lets cfg land
  assign issue_fire = (state == S_ISSUE) && (credits != '0);
  assign ret_fire   = busy && mem_rvalid && (cur_op == OP_READ);
  assign done       = (state == S_DONE);
  assign mem_valid  = issue_fire;
  assign mem_op     = cur_op;

  // ------------------------------------------------------------------------
  // FSM, size snapshot and issue counter
  // ------------------------------------------------------------------------

  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
    begin
      state     <= S_IDLE;
      cur_size  <= SIZE_8;
      cur_bus   <= SIZE_32;
      cur_op    <= OP_READ;
      issue_idx <= '0;
    end
    else
    begin
      unique case (state)
        S_IDLE:
          if (req_valid)
          begin
            state     <= S_ISSUE;
            cur_size  <= req_size;
            cur_bus   <= bus_size;            // width frozen for the whole transfer
            cur_op    <= req_op;
            issue_idx <= num_accesses(req_size, bus_size);  // msb part first
          end
        S_ISSUE:
          if (issue_fire)
          begin
            if (issue_idx == '0)
              state <= (cur_op == OP_READ) ? S_DRAIN : S_DONE;  // writes finish here
            else
              issue_idx <= issue_idx - 1'b1;
          end
        S_DRAIN:
          if (ret_fire && (ret_idx == '0))
            state <= S_DONE;                  // last read back
        S_DONE:
          state <= S_IDLE;
      endcase
    end
  end

  // return counter, read data comes back in issue order
  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
      ret_idx <= '0;
    else if (req_valid && req_ready)
      ret_idx <= num_accesses(req_size, bus_size);
    else if (ret_fire && (ret_idx != '0))
      ret_idx <= ret_idx - 1'b1;
  end

  // credit pool, independent of the FSM since write credits may trail done
  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
      credits <= credit_t'(CREDIT_MAX);
    else
      credits <= credits + credit_t'(mem_credit) - credit_t'(issue_fire);
  end

  a_no_issue_dry: assert property (@(posedge sys_clk6) disable iff (!n_sys_reset6)
    mem_valid |-> (credits != '0));

  a_credit_max: assert property (@(posedge sys_clk6) disable iff (!n_sys_reset6)
    credits <= credit_t'(CREDIT_MAX));

  a_req_size_legal: assert property (@(posedge sys_clk6) disable iff (!n_sys_reset6)
    (req_valid && req_ready) |-> (req_size != SIZE_RSVD));

endmodule

// ==== verilog/smc_cfg_regs.sv ====
`timescale 1ns/1ps

module smc_cfg_regs
  import smc_size_pkg::*;
(
  input  logic       sys_clk6,
  input  logic       n_sys_reset6,
  input  logic       cfg_we,
  input  xfer_size_e cfg_bus_size,
  input  logic       busy,                    // transfer in progress
  output xfer_size_e bus_size
);

  logic       pend_valid;                     // write parked during a transfer
  xfer_size_e pend_size;
  logic       wr_ok;

  assign wr_ok = cfg_we && (cfg_bus_size != SIZE_RSVD);  // reserved code dropped

  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
    begin
      bus_size   <= SIZE_32;                  // full width out of reset
      pend_valid <= 1'b0;
      pend_size  <= SIZE_32;
    end
    else if (wr_ok && !busy)
    begin
      bus_size   <= cfg_bus_size;             // idle, straight in
      pend_valid <= 1'b0;                     // newer write wins over a parked one
    end
    else if (wr_ok)
    begin
      pend_valid <= 1'b1;                     // later write replaces earlier
      pend_size  <= cfg_bus_size;
    end
    else if (pend_valid && !busy)
    begin
      bus_size   <= pend_size;                // apply once the transfer is over
      pend_valid <= 1'b0;
    end
  end

  a_bus_size_legal: assert property (@(posedge sys_clk6) disable iff (!n_sys_reset6)
    bus_size != SIZE_RSVD);

endmodule

// ==== verilog/smc_ctrl_pkg.sv ====
package smc_ctrl_pkg;

  // ------------------------------------------------------------------------
  // sequencer control types
  // ------------------------------------------------------------------------

  typedef enum logic [1:0] {
    S_IDLE  = 2'b00,                          // waiting for a host request
    S_ISSUE = 2'b01,                          // issuing accesses while credits last
    S_DRAIN = 2'b10,                          // reads out, waiting for returns
    S_DONE  = 2'b11                           // done pulse
  } seq_state_e;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } acc_op_e;

  localparam int CREDIT_W = 3;                // holds 0..7

  typedef logic [CREDIT_W-1:0] credit_t;

endpackage

// ==== verilog/smc_data_path.sv ====
`timescale 1ns/1ps

module smc_data_path
  import smc_size_pkg::*;
  import smc_ctrl_pkg::*;
(
  input  logic              sys_clk6,
  input  logic              n_sys_reset6,
  input  xfer_size_e        cur_size,
  input  xfer_size_e        cur_bus,
  input  acc_op_e           cur_op,
  input  acc_cnt_t          issue_idx,
  input  logic              issue_fire,
  input  acc_cnt_t          ret_idx,
  input  logic              ret_fire,
  input  logic [DATA_W-1:0] req_wdata,       // host holds it until done
  input  logic [DATA_W-1:0] mem_rdata,
  output logic [DATA_W-1:0] mem_wdata,
  output logic [DATA_W-1:0] rd_data
);

  logic [DATA_W-1:0] wr_part;                 // current part on the low lanes
  logic [DATA_W-1:0] rd_store;                // assembled read bytes
  logic [4:0]        wr_byte_ofs;             // bit offset for an 8-bit bus
  logic [4:0]        wr_half_ofs;             // bit offset for a 16-bit bus
  logic [4:0]        rd_byte_ofs;
  logic [4:0]        rd_half_ofs;

  // index k names byte k or halfword k of the host word
  assign wr_byte_ofs = {issue_idx, 3'b000};
  assign wr_half_ofs = {issue_idx[0], 4'b0000};
  assign rd_byte_ofs = {ret_idx, 3'b000};
  assign rd_half_ofs = {ret_idx[0], 4'b0000};

  // ------------------------------------------------------------------------
  // write steering
  // ------------------------------------------------------------------------

  always_comb
  begin
    wr_part = '0;                             // unused lanes stay zero
    unique case (cur_bus)
      SIZE_8:
        wr_part[7:0] = req_wdata[wr_byte_ofs +: 8];
      SIZE_16:
        wr_part[15:0] = req_wdata[wr_half_ofs +: 16];
      default:
        wr_part = req_wdata;                  // one full-width access
    endcase
  end

  // narrow transfer on a wide bus only drives its own low lanes
  assign mem_wdata = (issue_fire && (cur_op == OP_WRITE)) ?
                     (wr_part & size_mask(cur_size)) : '0;

  // ------------------------------------------------------------------------
  // read assembly
  // ------------------------------------------------------------------------

  always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
  begin
    if (!n_sys_reset6)
      rd_store <= '0;
    else if (ret_fire)
    begin
      unique case (cur_bus)
        SIZE_8:
          rd_store[rd_byte_ofs +: 8] <= mem_rdata[7:0];
        SIZE_16:
          rd_store[rd_half_ofs +: 16] <= mem_rdata[15:0];
        default:
          rd_store <= mem_rdata;              // whole word in one go
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // read output, narrow results copied across the host word
  // ------------------------------------------------------------------------

  always_comb
  begin
    unique case (cur_size)
      SIZE_8:
        rd_data = {4{rd_store[7:0]}};
      SIZE_16:
        rd_data = {2{rd_store[15:0]}};
      default:
        rd_data = rd_store;
    endcase
  end

endmodule

// ==== verilog/smc_mac_top.sv ====
`timescale 1ns/1ps

module smc_mac_top
  import smc_size_pkg::*;
  import smc_ctrl_pkg::*;
#(
  parameter int CREDIT_MAX = 4                // memory side outstanding limit
)
(
  input  logic              sys_clk6,
  input  logic              n_sys_reset6,
  // host side
  input  logic              req_valid,
  input  acc_op_e           req_op,
  input  xfer_size_e        req_size,
  input  logic [DATA_W-1:0] req_wdata,
  output logic              req_ready,
  output logic              done,
  output logic [DATA_W-1:0] rd_data,
  // configuration
  input  logic              cfg_we,
  input  xfer_size_e        cfg_bus_size,
  // external memory side
  output logic              mem_valid,
  output acc_op_e           mem_op,
  output logic [DATA_W-1:0] mem_wdata,
  input  logic              mem_credit,
  input  logic              mem_rvalid,
  input  logic [DATA_W-1:0] mem_rdata
);

  logic       busy;
  xfer_size_e bus_size;                       // live config value
  xfer_size_e cur_size;                       // per-transfer snapshot
  xfer_size_e cur_bus;
  acc_op_e    cur_op;
  acc_cnt_t   issue_idx;
  logic       issue_fire;
  acc_cnt_t   ret_idx;
  logic       ret_fire;

  smc_cfg_regs u_cfg_regs (
    .sys_clk6     (sys_clk6),
    .n_sys_reset6 (n_sys_reset6),
    .cfg_we       (cfg_we),
    .cfg_bus_size (cfg_bus_size),
    .busy         (busy),
    .bus_size     (bus_size)
  );

  smc_access_seq #(
    .CREDIT_MAX (CREDIT_MAX)
  ) u_access_seq (
    .sys_clk6     (sys_clk6),
    .n_sys_reset6 (n_sys_reset6),
    .req_valid    (req_valid),
    .req_op       (req_op),
    .req_size     (req_size),
    .bus_size     (bus_size),
    .req_ready    (req_ready),
    .busy         (busy),
    .cur_size     (cur_size),
    .cur_bus      (cur_bus),
    .cur_op       (cur_op),
    .issue_idx    (issue_idx),
    .issue_fire   (issue_fire),
    .ret_idx      (ret_idx),
    .ret_fire     (ret_fire),
    .done         (done),
    .mem_valid    (mem_valid),
    .mem_op       (mem_op),
    .mem_credit   (mem_credit),
    .mem_rvalid   (mem_rvalid)
  );

  smc_data_path u_data_path (
    .sys_clk6     (sys_clk6),
    .n_sys_reset6 (n_sys_reset6),
    .cur_size     (cur_size),
    .cur_bus      (cur_bus),
    .cur_op       (cur_op),
    .issue_idx    (issue_idx),
    .issue_fire   (issue_fire),
    .ret_idx      (ret_idx),
    .ret_fire     (ret_fire),
    .req_wdata    (req_wdata),
    .mem_rdata    (mem_rdata),
    .mem_wdata    (mem_wdata),
    .rd_data      (rd_data)
  );

endmodule

// ==== verilog/smc_size_pkg.sv ====
package smc_size_pkg;

  // ------------------------------------------------------------------------
  // transfer and external bus sizes
  // ------------------------------------------------------------------------

  localparam int DATA_W = 32;                 // host and external data width

  typedef enum logic [1:0] {
    SIZE_8    = 2'b00,
    SIZE_16   = 2'b01,
    SIZE_32   = 2'b10,
    SIZE_RSVD = 2'b11                         // never a legal size
  } xfer_size_e;

  typedef logic [1:0] acc_cnt_t;              // access index, 3 down to 0

  // last access index for a transfer on a bus, i.e. accesses minus one
  function automatic acc_cnt_t num_accesses(xfer_size_e xfer, xfer_size_e bus);
    logic [1:0] diff;
    if (xfer <= bus)
      return '0;                              // fits in a single access
    diff = xfer - bus;                        // log2 of the access count
    return acc_cnt_t'((4'd1 << diff) - 4'd1);
  endfunction

  // lanes a transfer of this size actually carries
  function automatic logic [DATA_W-1:0] size_mask(xfer_size_e xfer);
    unique case (xfer)
      SIZE_8:  return 32'h0000_00ff;
      SIZE_16: return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

endpackage
